//--- Makefile
TOP = tb_rv_top

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): rv_top.f $(wildcard *.sv) rv_top_golden.txt
	verilator --binary --assert -f rv_top.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f rv_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  wire rv_pkg::alu_op_e      op_i,
    input  wire [rv_pkg::xlen-1:0]    a_i,
    input  wire [rv_pkg::xlen-1:0]    b_i,
    output logic [rv_pkg::xlen-1:0]   y_o
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            alu_add:  y_o = a_i + b_i;
            alu_sub:  y_o = a_i - b_i;
            alu_and:  y_o = a_i & b_i;
            alu_or:   y_o = a_i | b_i;
            alu_xor:  y_o = a_i ^ b_i;
            alu_sll:  y_o = a_i << shamt;
            alu_srl:  y_o = a_i >> shamt;
            alu_sra:  y_o = $unsigned($signed(a_i) >>> shamt);
            alu_slt:  y_o = {{(xlen - 1){1'b0}}, $signed(a_i) < $signed(b_i)};
            alu_sltu: y_o = {{(xlen - 1){1'b0}}, a_i < b_i};
            default:  y_o = '0;
        endcase
    end

    // no clock here, so checked as a deferred assertion
    always_comb begin
        if (!$isunknown({op_i, a_i, b_i})) begin
            a_y_known: assert final (!$isunknown(y_o));
        end
    end

endmodule

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire                          clk,
    input  wire                          rst_n,
    output logic [rv_pkg::xlen-1:0]      imem_addr_o,
    input  wire rv_pkg::inst_u           imem_data_i,
    output rv_pkg::dmem_req_t            dmem_req_o,
    input  wire [rv_pkg::xlen-1:0]       dmem_rdata_i,
    output logic                         exit_o
);
    import rv_pkg::*;

    logic [xlen-1:0] pc;
    logic            halted;
    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] op2;
    logic [xlen-1:0] alu_y;
    logic [xlen-1:0] wb_data;
    logic            rf_we;

    rv_decoder i_rv_decoder (
        .inst_i (imem_data_i),
        .ctrl_o (ctrl),
        .imm_o  (imm)
    );

    rv_regfile i_rv_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_i      (imem_data_i.r.rs1),
        .rs2_i      (imem_data_i.r.rs2),
        .rd_i       (imem_data_i.r.rd),
        .we_i       (rf_we),
        .wd_i       (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    assign op2 = (ctrl.op2_sel == op2_imm) ? imm : rs2_data;

    rv_alu i_rv_alu (
        .op_i (ctrl.alu_op),
        .a_i  (rs1_data),
        .b_i  (op2),
        .y_o  (alu_y)
    );

    assign wb_data = (ctrl.wb_sel == wb_mem) ? dmem_rdata_i : alu_y;
    assign rf_we   = ctrl.rf_we & ~halted;

    assign dmem_req_o.we    = ctrl.mem_we & ~halted;
    assign dmem_req_o.addr  = alu_y; // rs1 + imm for lw/sw
    assign dmem_req_o.wdata = rs2_data;

    assign imem_addr_o = pc;
    assign exit_o      = halted;

    // pc stays on the halt instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (!halted) begin
            if (!ctrl.halt) begin
                pc <= pc + xlen'(4);
            end
            halted <= ctrl.halt;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

    a_halt_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted && $stable(pc) && !dmem_req_o.we && !rf_we);

endmodule

`default_nettype wire

//--- rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  wire rv_pkg::inst_u           inst_i,
    output rv_pkg::ctrl_t                ctrl_o,
    output logic [rv_pkg::xlen-1:0]      imm_o
);
    import rv_pkg::*;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             alt;
    logic             alt_ok;
    logic             f7_legal;
    logic             shift_f3;
    alu_op_e          alu_sel;
    logic [imm_w-1:0] imm_sel;

    assign opcode = inst_i.r.opcode;
    assign funct3 = inst_i.r.funct3;
    assign funct7 = inst_i.r.funct7;

    assign alt      = (funct7 == f7_alt);
    assign alt_ok   = alt && ((funct3 == f3_sr) || (funct3 == f3_add && opcode == op_reg));
    assign f7_legal = (funct7 == f7_base) || alt_ok;
    assign shift_f3 = (funct3 == f3_sll) || (funct3 == f3_sr); // imm form checks funct7 too

    always_comb begin
        alu_sel = alu_add;
        case (funct3)
            f3_add:  alu_sel = (alt && opcode == op_reg) ? alu_sub : alu_add;
            f3_sll:  alu_sel = alu_sll;
            f3_slt:  alu_sel = alu_slt;
            f3_sltu: alu_sel = alu_sltu;
            f3_xor:  alu_sel = alu_xor;
            f3_sr:   alu_sel = alt ? alu_sra : alu_srl;
            f3_or:   alu_sel = alu_or;
            f3_and:  alu_sel = alu_and;
            default: alu_sel = alu_add;
        endcase
    end

    // anything outside the subset stays all zero, i.e. a nop
    always_comb begin
        ctrl_o = '0;
        case (opcode)
            op_load: begin
                if (inst_i.i.funct3 == f3_lw) begin
                    ctrl_o.op2_sel = op2_imm;
                    ctrl_o.wb_sel  = wb_mem;
                    ctrl_o.rf_we   = 1'b1;
                end
            end
            op_store: begin
                if (inst_i.s.funct3 == f3_sw) begin
                    ctrl_o.op2_sel = op2_imm; // addr = rs1 + imm_s
                    ctrl_o.mem_we  = 1'b1;
                end
            end
            op_reg: begin
                if (f7_legal) begin
                    ctrl_o.alu_op = alu_sel;
                    ctrl_o.rf_we  = 1'b1;
                end
            end
            op_imm: begin
                if (!shift_f3 || f7_legal) begin
                    ctrl_o.alu_op  = alu_sel;
                    ctrl_o.op2_sel = op2_imm;
                    ctrl_o.rf_we   = 1'b1;
                end
            end
            op_system: ctrl_o.halt = 1'b1;
            default: ctrl_o = '0;
        endcase
    end

    assign imm_sel = (opcode == op_store) ? {inst_i.s.imm_hi, inst_i.s.imm_lo} : inst_i.i.imm;
    assign imm_o   = {{(xlen - imm_w){imm_sel[imm_w-1]}}, imm_sel}; // sign extend

endmodule

`default_nettype wire

//--- rv_dmem.sv
`timescale 1ns/1ps
`default_nettype none

module rv_dmem (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire rv_pkg::dmem_req_t       req_i,
    output logic [rv_pkg::xlen-1:0]      rdata_o
);
    import rv_pkg::*;

    logic [xlen-1:0]    mem [dmem_words];
    logic [dmem_aw-1:0] word_addr;

    assign word_addr = req_i.addr[dmem_aw+1:2]; // upper bits wrap
    assign rdata_o   = mem[word_addr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < dmem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (req_i.we) begin
            mem[word_addr] <= req_i.wdata;
        end
    end

    // word access only
    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        req_i.we |-> req_i.addr[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int unsigned xlen       = 32;
    localparam int unsigned reg_cnt    = 32;
    localparam int unsigned reg_aw     = 5;
    localparam int unsigned imm_w      = 12;
    localparam int unsigned dmem_words = 64;
    localparam int unsigned dmem_aw    = 6;

    // major opcodes
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_system = 7'b1110011; // ecall / ebreak, used as halt

    localparam logic [2:0] f3_lw   = 3'b010;
    localparam logic [2:0] f3_sw   = 3'b010;
    localparam logic [2:0] f3_add  = 3'b000; // add, sub, addi
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101; // srl and sra
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000; // sub, sra, srai

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        op2_rs2 = 2'd0,
        op2_imm = 2'd1
    } op2_sel_e;

    typedef enum logic {
        wb_alu = 1'b0,
        wb_mem = 1'b1
    } wb_sel_e;

    typedef struct packed {
        logic [6:0]        funct7;
        logic [reg_aw-1:0] rs2;
        logic [reg_aw-1:0] rs1;
        logic [2:0]        funct3;
        logic [reg_aw-1:0] rd;
        logic [6:0]        opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [imm_w-1:0]  imm;
        logic [reg_aw-1:0] rs1;
        logic [2:0]        funct3;
        logic [reg_aw-1:0] rd;
        logic [6:0]        opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]        imm_hi;
        logic [reg_aw-1:0] rs2;
        logic [reg_aw-1:0] rs1;
        logic [2:0]        funct3;
        logic [4:0]        imm_lo;
        logic [6:0]        opcode;
    } s_fmt_t;

    // one fetched word, three views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
    } inst_u;

    typedef struct packed {
        alu_op_e  alu_op;
        op2_sel_e op2_sel;
        wb_sel_e  wb_sel;
        logic     rf_we;
        logic     mem_we;
        logic     halt;
    } ctrl_t;

    typedef struct packed {
        logic            we;
        logic [xlen-1:0] addr;  // byte address
        logic [xlen-1:0] wdata;
    } dmem_req_t;

endpackage

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire [rv_pkg::reg_aw-1:0]     rs1_i,
    input  wire [rv_pkg::reg_aw-1:0]     rs2_i,
    input  wire [rv_pkg::reg_aw-1:0]     rd_i,
    input  wire                          we_i,
    input  wire [rv_pkg::xlen-1:0]       wd_i,
    output logic [rv_pkg::xlen-1:0]      rs1_data_o,
    output logic [rv_pkg::xlen-1:0]      rs2_data_o
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [reg_cnt];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_cnt; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin // x0 writes dropped
            regs[rd_i] <= wd_i;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

    // x0 storage is never disturbed by any write since reset
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        regs[0] == '0);

endmodule

`default_nettype wire

//--- rv_top.f
rv_pkg.sv
rv_decoder.sv
rv_alu.sv
rv_regfile.sv
rv_core.sv
rv_dmem.sv
rv_top.sv
tb_clk_gen.sv
tb_rv_top.sv

//--- rv_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_top (
    input  wire                          clk,
    input  wire                          rst_n,
    output logic [rv_pkg::xlen-1:0]      imem_addr_o,
    input  wire rv_pkg::inst_u           imem_data_i,
    output rv_pkg::dmem_req_t            dmem_req_o,
    output logic                         exit_o
);
    import rv_pkg::*;

    dmem_req_t       dmem_req;
    logic [xlen-1:0] dmem_rdata;

    rv_core i_rv_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr_o),
        .imem_data_i  (imem_data_i),
        .dmem_req_o   (dmem_req),
        .dmem_rdata_i (dmem_rdata),
        .exit_o       (exit_o)
    );

    rv_dmem i_rv_dmem (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (dmem_req),
        .rdata_o (dmem_rdata)
    );

    assign dmem_req_o = dmem_req; // stores visible outside

endmodule

`default_nettype wire

//--- rv_top_golden.txt
// each entry is instruction, expected store we, store addr, store data, exit (hex)
// addr and data are compared only when we is 1
12300093 0 00000000 00000000 0 // addi x1,x0,0x123
FFB00113 0 00000000 00000000 0 // addi x2,x0,-5
002081B3 0 00000000 00000000 0 // add x3,x1,x2
40310233 0 00000000 00000000 0 // sub x4,x2,x3
EE40A6A3 1 00000010 FFFFFEDD 0 // sw x4,-275(x1)
001242B3 0 00000000 00000000 0 // xor x5,x4,x1
0032F333 0 00000000 00000000 0 // and x6,x5,x3
00136333 0 00000000 00000000 0 // or x6,x6,x1
00602223 1 00000004 0000013F 0 // sw x6,4(x0)
001123B3 0 00000000 00000000 0 // slt x7,x2,x1
0020B433 0 00000000 00000000 0 // sltu x8,x1,x2
00112493 0 00000000 00000000 0 // slti x9,x2,1
FFF0B513 0 00000000 00000000 0 // sltiu x10,x1,-1
008383B3 0 00000000 00000000 0 // add x7,x7,x8
00A484B3 0 00000000 00000000 0 // add x9,x9,x10
009383B3 0 00000000 00000000 0 // add x7,x7,x9
5A03C393 0 00000000 00000000 0 // xori x7,x7,0x5a0
00B3E393 0 00000000 00000000 0 // ori x7,x7,0xb
FFE3F393 0 00000000 00000000 0 // andi x7,x7,-2
00702423 1 00000008 000005AE 0 // sw x7,8(x0)
00411593 0 00000000 00000000 0 // slli x11,x2,4
4025D613 0 00000000 00000000 0 // srai x12,x11,2
0095D6B3 0 00000000 00000000 0 // srl x13,x11,x9
00D64733 0 00000000 00000000 0 // xor x14,x12,x13
40975733 0 00000000 00000000 0 // sra x14,x14,x9
01875793 0 00000000 00000000 0 // srli x15,x14,24
009797B3 0 00000000 00000000 0 // sll x15,x15,x9
00F02623 1 0000000C 000003C0 0 // sw x15,12(x0)
01002803 0 00000000 00000000 0 // lw x16,16(x0)
F100A6A3 1 00000030 FFFFFEDD 0 // sw x16,-243(x1)
05508013 0 00000000 00000000 0 // addi x0,x1,0x55
00002A23 1 00000014 00000000 0 // sw x0,20(x0)
00000073 0 00000000 00000000 0 // ecall, halt
00602223 0 00000000 00000000 1 // sw x6,4(x0) while halted
00100093 0 00000000 00000000 1 // addi x1,x0,1 while halted
00102023 0 00000000 00000000 1 // sw x1,0(x0) while halted

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o
);
    localparam time half_period = 20ns; // 40 ns clock

    initial begin
        clk_o = 1'b0;
        forever #(half_period) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

//--- tb_rv_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_top;
    import rv_pkg::*;

    localparam int entries    = 36;
    localparam int cols       = 5;  // instr, we, addr, data, exit
    localparam int rst_cycles = 8;
    localparam int max_cycles = entries + rst_cycles + 20;
    localparam logic [31:0] nop = 32'h0000_0013; // addi x0,x0,0

    logic            clk;
    logic            rst_n;
    logic [xlen-1:0] imem_addr;
    inst_u           imem_data;
    dmem_req_t       dmem_req;
    logic            exit_flag;

    logic [31:0] golden [entries*cols];
    int          cycles = 0;
    int          pc_idx;
    int          exit_hold;

    tb_clk_gen i_tb_clk_gen (
        .clk_o (clk)
    );

    rv_top i_rv_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .dmem_req_o  (dmem_req),
        .exit_o      (exit_flag)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run aborted");
    endtask

    task automatic check_pc(input int idx, input logic [xlen-1:0] act);
        logic [xlen-1:0] exp;
        exp = xlen'(idx * 4);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERR imem_addr_o exp %08h got %08h", exp, act));
        end
    endtask

    // addr and wdata only matter for a store
    task automatic check_req(input dmem_req_t exp, input dmem_req_t act);
        if (act.we !== exp.we) begin
            stop_with_failure($sformatf("ERR dmem_req_o.we exp %0h got %0h", exp.we, act.we));
        end else if (exp.we && act.addr !== exp.addr) begin
            stop_with_failure($sformatf("ERR dmem_req_o.addr exp %08h got %08h",
                                        exp.addr, act.addr));
        end else if (exp.we && act.wdata !== exp.wdata) begin
            stop_with_failure($sformatf("ERR dmem_req_o.wdata exp %08h got %08h",
                                        exp.wdata, act.wdata));
        end
    endtask

    task automatic check_exit(input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERR exit_o exp %0h got %0h", exp, act));
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            stop_with_failure($sformatf("timeout after %0d cycles, program did not finish",
                                        cycles));
        end
    end

    initial begin
        dmem_req_t exp_req;
        logic      exp_exit;

        rst_n     = 1'b0;
        imem_data = nop; // nop while in reset
        pc_idx    = 0;
        exit_hold = 0;
        $readmemh("rv_top_golden.txt", golden);
        if (golden[entries*cols-1] !== 32'h1) begin
            stop_with_failure("golden file is missing, short or does not end halted");
        end

        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < entries; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            imem_data = golden[i*cols];
            #5; // let the single-cycle path settle

            exp_req.we    = golden[i*cols+1][0];
            exp_req.addr  = golden[i*cols+2];
            exp_req.wdata = golden[i*cols+3];
            exp_exit      = golden[i*cols+4][0];
            if (!exp_exit) begin
                pc_idx = i; // pc freezes on the halt entry
            end

            check_pc(pc_idx, imem_addr);
            check_req(exp_req, dmem_req);
            check_exit(exp_exit, exit_flag);
            if (exit_flag) begin
                exit_hold++;
            end
        end

        if (exit_hold >= 3) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_with_failure("exit_o did not stay high for three cycles after halt");
        end
    end

endmodule

`default_nettype wire
